//--- common/lsu_pkg.sv
package lsu_pkg;

  localparam int data_w = 32;
  localparam int tag_w = 6;
  localparam int addr_w = 4;
  localparam int mem_depth = 1 << addr_w; // word-addressed.

  typedef enum logic {
    op_load,
    op_store
  } lsu_op_e;

  // imm is a word offset added to the base operand.
  typedef struct packed {
    lsu_op_e           op;
    logic [addr_w-1:0] imm;
  } uop_t;

endpackage

//--- hdl/lsu_dispatch.sv
`timescale 1ns/100ps
module lsu_dispatch #(
  parameter int rs_depth = 4
) (
  input  logic                       disp_valid,
  input  lsu_pkg::uop_t              disp_op,
  input  logic [lsu_pkg::tag_w-1:0]  disp_tag,
  input  logic [lsu_pkg::data_w-1:0] disp_base_val,
  input  logic [lsu_pkg::tag_w-1:0]  disp_base_tag,
  input  logic                       disp_base_rdy,
  input  logic [lsu_pkg::data_w-1:0] disp_data_val,
  input  logic [lsu_pkg::tag_w-1:0]  disp_data_tag,
  input  logic                       disp_data_rdy,
  input  logic [rs_depth-1:0]        busy_vector,
  input  logic                       cdb_valid,
  input  logic [lsu_pkg::tag_w-1:0]  cdb_tag,
  input  logic [lsu_pkg::data_w-1:0] cdb_value,

  output logic [rs_depth-1:0]        entry_wen,
  output lsu_pkg::uop_t              in_op,
  output logic [lsu_pkg::tag_w-1:0]  in_dst_tag,
  output logic [lsu_pkg::data_w-1:0] in_v1,
  output logic [lsu_pkg::tag_w-1:0]  in_q1,
  output logic                       in_r1,
  output logic [lsu_pkg::data_w-1:0] in_v2,
  output logic [lsu_pkg::tag_w-1:0]  in_q2,
  output logic                       in_r2,
  output logic                       rs_full
);

  logic found;
  logic base_hit;
  logic data_hit;

  always_comb begin
    found     = 1'b0;
    entry_wen = '0;
    for (int i = 0; i < rs_depth; i++) begin
      if (!busy_vector[i] && !found) begin
        found        = 1'b1;
        entry_wen[i] = disp_valid; // no free slot means the strobe is lost.
      end
    end
  end

  assign rs_full = &busy_vector;

  // catch a tag broadcast in the dispatch cycle itself.
  assign base_hit = cdb_valid && !disp_base_rdy && (cdb_tag == disp_base_tag);
  assign data_hit = cdb_valid && !disp_data_rdy && (cdb_tag == disp_data_tag);

  assign in_op      = disp_op;
  assign in_dst_tag = disp_tag;
  assign in_v1      = base_hit ? cdb_value : disp_base_val;
  assign in_q1      = disp_base_tag;
  assign in_r1      = disp_base_rdy || base_hit;
  assign in_v2      = data_hit ? cdb_value : disp_data_val;
  assign in_q2      = disp_data_tag;
  assign in_r2      = disp_data_rdy || data_hit;

endmodule

//--- lsu_rs/reservation_station_lsu.sv
`timescale 1ns/100ps
module reservation_station_lsu #(
  parameter int rs_depth = 4,
  localparam int rs_idx_w = $clog2(rs_depth)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush,

  input  logic [rs_depth-1:0]         entry_wen,
  input  lsu_pkg::uop_t               in_op,
  input  logic [lsu_pkg::tag_w-1:0]   in_dst_tag,
  input  logic [lsu_pkg::data_w-1:0]  in_v1,
  input  logic [lsu_pkg::tag_w-1:0]   in_q1,
  input  logic                        in_r1,
  input  logic [lsu_pkg::data_w-1:0]  in_v2,
  input  logic [lsu_pkg::tag_w-1:0]   in_q2,
  input  logic                        in_r2,

  input  logic                        cdb_valid,
  input  logic [lsu_pkg::tag_w-1:0]   cdb_tag,
  input  logic [lsu_pkg::data_w-1:0]  cdb_value,

  input  logic [rs_depth-1:0]         issue_grant,
  input  logic [rs_idx_w-1:0]         sel_idx,

  output logic [rs_depth-1:0]         ready_mask,
  output logic [rs_depth-1:0]         busy_vector,
  output logic [lsu_pkg::tag_w-1:0]   entry_tag [rs_depth],

  output lsu_pkg::uop_t               out_op,
  output logic [lsu_pkg::tag_w-1:0]   out_dst_tag,
  output logic [lsu_pkg::data_w-1:0]  out_v1,
  output logic [lsu_pkg::data_w-1:0]  out_v2
);

  logic [rs_depth-1:0]        busy;
  lsu_pkg::uop_t              op_arr  [rs_depth];
  logic [lsu_pkg::tag_w-1:0]  dst_arr [rs_depth];
  logic [lsu_pkg::data_w-1:0] v1_arr  [rs_depth];
  logic [lsu_pkg::tag_w-1:0]  q1_arr  [rs_depth];
  logic                       r1_arr  [rs_depth];
  logic [lsu_pkg::data_w-1:0] v2_arr  [rs_depth];
  logic [lsu_pkg::tag_w-1:0]  q2_arr  [rs_depth];
  logic                       r2_arr  [rs_depth];
  logic [rs_depth-1:0]        load_blocked;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else if (flush) begin
      busy <= '0;
    end else begin
      busy <= (busy & ~issue_grant) | entry_wen; // dispatch only hits free slots.
    end
  end

  // operands arriving with dispatch are already merged with the cdb.
  always_ff @(posedge clk) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (entry_wen[i]) begin
        op_arr[i]  <= in_op;
        dst_arr[i] <= in_dst_tag;
        v1_arr[i]  <= in_v1;
        q1_arr[i]  <= in_q1;
        r1_arr[i]  <= in_r1;
        v2_arr[i]  <= in_v2;
        q2_arr[i]  <= in_q2;
        r2_arr[i]  <= in_r2;
      end else if (busy[i] && cdb_valid) begin
        if (!r1_arr[i] && (q1_arr[i] == cdb_tag)) begin
          v1_arr[i] <= cdb_value;
          r1_arr[i] <= 1'b1;
        end
        if (!r2_arr[i] && (q2_arr[i] == cdb_tag)) begin
          v2_arr[i] <= cdb_value;
          r2_arr[i] <= 1'b1;
        end
      end
    end
  end

  // a load waits while any older store is still in the station.
  always_comb begin
    for (int m = 0; m < rs_depth; m++) begin
      load_blocked[m] = 1'b0;
      for (int n = 0; n < rs_depth; n++) begin
        if (busy[n] && (op_arr[n].op == lsu_pkg::op_store) &&
            (dst_arr[n] < dst_arr[m])) begin
          load_blocked[m] = 1'b1;
        end
      end
      ready_mask[m] = busy[m] && r1_arr[m] && r2_arr[m] &&
                      !((op_arr[m].op == lsu_pkg::op_load) && load_blocked[m]);
    end
  end

  assign out_op      = op_arr[sel_idx];
  assign out_dst_tag = dst_arr[sel_idx];
  assign out_v1      = v1_arr[sel_idx];
  assign out_v2      = v2_arr[sel_idx];

  assign entry_tag   = dst_arr;
  assign busy_vector = busy;

endmodule

//--- lsu_rs/lsu_issue_select.sv
`timescale 1ns/100ps
module lsu_issue_select #(
  parameter int rs_depth = 4,
  localparam int rs_idx_w = $clog2(rs_depth)
) (
  input  logic [rs_depth-1:0]       ready_mask,
  input  logic [lsu_pkg::tag_w-1:0] entry_tag [rs_depth],
  input  logic                      exec_stall,
  output logic [rs_depth-1:0]       issue_grant,
  output logic                      issue_valid,
  output logic [rs_idx_w-1:0]       sel_idx
);

  logic                      found;
  logic [lsu_pkg::tag_w-1:0] best_tag;

  // oldest ready entry wins.
  always_comb begin
    found    = 1'b0;
    best_tag = '0;
    sel_idx  = '0;
    for (int i = 0; i < rs_depth; i++) begin
      if (ready_mask[i] && (!found || (entry_tag[i] < best_tag))) begin
        found    = 1'b1;
        best_tag = entry_tag[i];
        sel_idx  = rs_idx_w'(i);
      end
    end
    issue_grant = '0;
    if (found && !exec_stall) begin
      issue_grant[sel_idx] = 1'b1;
    end
  end

  assign issue_valid = |issue_grant;

endmodule

//--- hdl/lsu_exec.sv
`timescale 1ns/100ps
module lsu_exec (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       issue_valid,
  input  lsu_pkg::uop_t              out_op,
  input  logic [lsu_pkg::tag_w-1:0]  out_dst_tag,
  input  logic [lsu_pkg::data_w-1:0] out_v1,
  input  logic [lsu_pkg::data_w-1:0] out_v2,
  input  logic                       res_ack,
  output logic                       res_valid,
  output logic [lsu_pkg::tag_w-1:0]  res_tag,
  output logic [lsu_pkg::data_w-1:0] res_value,
  output logic                       exec_stall
);

  logic [lsu_pkg::data_w-1:0] mem [lsu_pkg::mem_depth];
  logic [lsu_pkg::addr_w-1:0] issue_addr;

  logic                       stg_valid;
  lsu_pkg::lsu_op_e           stg_op;
  logic [lsu_pkg::tag_w-1:0]  stg_tag;
  logic [lsu_pkg::addr_w-1:0] stg_addr;
  logic [lsu_pkg::data_w-1:0] stg_data;

  logic res_busy;
  logic stg_hold;
  logic load_go;
  logic store_go;

  assign issue_addr = out_v1[lsu_pkg::addr_w-1:0] + out_op.imm; // wraps in 16 words.

  assign res_busy   = res_valid && !res_ack;
  assign stg_hold   = stg_valid && (stg_op == lsu_pkg::op_load) && res_busy;
  assign load_go    = stg_valid && (stg_op == lsu_pkg::op_load) && !res_busy;
  assign store_go   = stg_valid && (stg_op == lsu_pkg::op_store);
  assign exec_stall = res_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_valid <= 1'b0;
      res_valid <= 1'b0;
    end else if (flush) begin
      stg_valid <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      if (!stg_hold) begin
        stg_valid <= issue_valid;
      end
      if (load_go) begin
        res_valid <= 1'b1;
      end else if (res_ack) begin
        res_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      stg_op   <= out_op.op;
      stg_tag  <= out_dst_tag;
      stg_addr <= issue_addr;
      stg_data <= out_v2;
    end
    if (load_go) begin
      res_tag   <= stg_tag;
      res_value <= mem[stg_addr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < lsu_pkg::mem_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (store_go) begin
      mem[stg_addr] <= stg_data;
    end
  end

endmodule

//--- hdl/cdb_arbiter.sv
`timescale 1ns/100ps
module cdb_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ext_valid,
  input  logic [lsu_pkg::tag_w-1:0]  ext_tag,
  input  logic [lsu_pkg::data_w-1:0] ext_value,
  input  logic                       res_valid,
  input  logic [lsu_pkg::tag_w-1:0]  res_tag,
  input  logic [lsu_pkg::data_w-1:0] res_value,
  output logic                       res_ack,
  output logic                       cdb_valid,
  output logic [lsu_pkg::tag_w-1:0]  cdb_tag,
  output logic [lsu_pkg::data_w-1:0] cdb_value
);

  assign res_ack = res_valid && !ext_valid; // ext cannot be held off.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= ext_valid || res_valid;
    end
  end

  always_ff @(posedge clk) begin
    cdb_tag   <= ext_valid ? ext_tag : res_tag;
    cdb_value <= ext_valid ? ext_value : res_value;
  end

endmodule

//--- hdl/lsu_top.sv
`timescale 1ns/100ps
module lsu_top #(
  parameter int rs_depth = 4,
  localparam int rs_idx_w = $clog2(rs_depth)
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       disp_valid,
  input  lsu_pkg::uop_t              disp_op,
  input  logic [lsu_pkg::tag_w-1:0]  disp_tag,
  input  logic [lsu_pkg::data_w-1:0] disp_base_val,
  input  logic [lsu_pkg::tag_w-1:0]  disp_base_tag,
  input  logic                       disp_base_rdy,
  input  logic [lsu_pkg::data_w-1:0] disp_data_val,
  input  logic [lsu_pkg::tag_w-1:0]  disp_data_tag,
  input  logic                       disp_data_rdy,
  input  logic                       ext_valid,
  input  logic [lsu_pkg::tag_w-1:0]  ext_tag,
  input  logic [lsu_pkg::data_w-1:0] ext_value,
  output logic                       rs_full,
  output logic                       cdb_valid,
  output logic [lsu_pkg::tag_w-1:0]  cdb_tag,
  output logic [lsu_pkg::data_w-1:0] cdb_value
);

  logic [rs_depth-1:0]        entry_wen;
  lsu_pkg::uop_t              in_op;
  logic [lsu_pkg::tag_w-1:0]  in_dst_tag;
  logic [lsu_pkg::data_w-1:0] in_v1;
  logic [lsu_pkg::tag_w-1:0]  in_q1;
  logic                       in_r1;
  logic [lsu_pkg::data_w-1:0] in_v2;
  logic [lsu_pkg::tag_w-1:0]  in_q2;
  logic                       in_r2;

  logic [rs_depth-1:0]        busy_vector;
  logic [rs_depth-1:0]        ready_mask;
  logic [lsu_pkg::tag_w-1:0]  entry_tag [rs_depth];
  logic [rs_depth-1:0]        issue_grant;
  logic                       issue_valid;
  logic [rs_idx_w-1:0]        sel_idx;

  lsu_pkg::uop_t              out_op;
  logic [lsu_pkg::tag_w-1:0]  out_dst_tag;
  logic [lsu_pkg::data_w-1:0] out_v1;
  logic [lsu_pkg::data_w-1:0] out_v2;

  logic                       exec_stall;
  logic                       res_valid;
  logic [lsu_pkg::tag_w-1:0]  res_tag;
  logic [lsu_pkg::data_w-1:0] res_value;
  logic                       res_ack;

  lsu_dispatch #(.rs_depth(rs_depth)) dispatch_i (
    .disp_valid, .disp_op, .disp_tag,
    .disp_base_val, .disp_base_tag, .disp_base_rdy,
    .disp_data_val, .disp_data_tag, .disp_data_rdy,
    .busy_vector, .cdb_valid, .cdb_tag, .cdb_value,
    .entry_wen, .in_op, .in_dst_tag,
    .in_v1, .in_q1, .in_r1, .in_v2, .in_q2, .in_r2,
    .rs_full
  );

  reservation_station_lsu #(.rs_depth(rs_depth)) rs_i (
    .clk, .rst_n, .flush,
    .entry_wen, .in_op, .in_dst_tag,
    .in_v1, .in_q1, .in_r1, .in_v2, .in_q2, .in_r2,
    .cdb_valid, .cdb_tag, .cdb_value,
    .issue_grant, .sel_idx,
    .ready_mask, .busy_vector, .entry_tag,
    .out_op, .out_dst_tag, .out_v1, .out_v2
  );

  lsu_issue_select #(.rs_depth(rs_depth)) select_i (
    .ready_mask, .entry_tag, .exec_stall,
    .issue_grant, .issue_valid, .sel_idx
  );

  lsu_exec exec_i (
    .clk, .rst_n, .flush, .issue_valid,
    .out_op, .out_dst_tag, .out_v1, .out_v2,
    .res_ack, .res_valid, .res_tag, .res_value, .exec_stall
  );

  cdb_arbiter arbiter_i (
    .clk, .rst_n,
    .ext_valid, .ext_tag, .ext_value,
    .res_valid, .res_tag, .res_value,
    .res_ack, .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/100ps
module tb_clock #(
  parameter real period_ns = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(period_ns / 2.0) clk = ~clk; // half period per toggle.

endmodule

//--- verification/lsu_tb.sv
`timescale 1ns/100ps
module lsu_tb;

  localparam int rs_depth = 4;
  localparam int timeout_cycles = 40;

  logic                       clk;
  logic                       rst_n;
  logic                       flush;
  logic                       disp_valid;
  lsu_pkg::uop_t              disp_op;
  logic [lsu_pkg::tag_w-1:0]  disp_tag;
  logic [lsu_pkg::data_w-1:0] disp_base_val;
  logic [lsu_pkg::tag_w-1:0]  disp_base_tag;
  logic                       disp_base_rdy;
  logic [lsu_pkg::data_w-1:0] disp_data_val;
  logic [lsu_pkg::tag_w-1:0]  disp_data_tag;
  logic                       disp_data_rdy;
  logic                       ext_valid;
  logic [lsu_pkg::tag_w-1:0]  ext_tag;
  logic [lsu_pkg::data_w-1:0] ext_value;
  logic                       rs_full;
  logic                       cdb_valid;
  logic [lsu_pkg::tag_w-1:0]  cdb_tag;
  logic [lsu_pkg::data_w-1:0] cdb_value;

  logic [lsu_pkg::data_w-1:0] model_mem [lsu_pkg::mem_depth];
  logic [lsu_pkg::addr_w-1:0] saved_addr;
  logic [31:0]                lfsr_state;
  int                         error_count;
  int                         pass_count;
  int                         fail_count;

  tb_clock clock_i (.clk);

  lsu_top #(.rs_depth(rs_depth)) dut_i (.*);

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] next_rand(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [lsu_pkg::addr_w-1:0] word_addr(
      input logic [lsu_pkg::data_w-1:0] base, input logic [lsu_pkg::addr_w-1:0] imm);
    return base[lsu_pkg::addr_w-1:0] + imm; // wraps within the memory.
  endfunction

  task automatic check_data(input logic [lsu_pkg::data_w-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_tag(input logic [lsu_pkg::tag_w-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic dispatch_uop(input lsu_pkg::lsu_op_e op, input logic [lsu_pkg::addr_w-1:0] imm,
      input logic [lsu_pkg::tag_w-1:0] tag, input logic [lsu_pkg::data_w-1:0] base,
      input logic base_rdy, input logic [lsu_pkg::tag_w-1:0] base_tag,
      input logic [lsu_pkg::data_w-1:0] data, input logic data_rdy,
      input logic [lsu_pkg::tag_w-1:0] data_tag);
    disp_valid    = 1'b1;
    disp_op.op    = op;
    disp_op.imm   = imm;
    disp_tag      = tag;
    disp_base_val = base;
    disp_base_rdy = base_rdy;
    disp_base_tag = base_tag;
    disp_data_val = data;
    disp_data_rdy = data_rdy;
    disp_data_tag = data_tag;
    @(negedge clk);
    disp_valid = 1'b0;
  endtask

  // ext has no back-pressure, so it must show on the cdb one cycle later.
  task automatic ext_strobe(input logic [lsu_pkg::tag_w-1:0] tag,
      input logic [lsu_pkg::data_w-1:0] value);
    ext_valid = 1'b1;
    ext_tag   = tag;
    ext_value = value;
    @(negedge clk);
    ext_valid = 1'b0;
    check_flag(cdb_valid, 1'b1, "cdb_valid after ext strobe");
    check_tag(cdb_tag, tag, "ext tag on cdb");
    check_data(cdb_value, value, "ext value on cdb");
  endtask

  task automatic wait_result(input logic [lsu_pkg::tag_w-1:0] tag,
      input logic [lsu_pkg::data_w-1:0] exp);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(cdb_valid && cdb_tag == tag) && n < timeout_cycles);
    if (cdb_valid && cdb_tag == tag) begin
      check_data(cdb_value, exp, $sformatf("load %0d value", tag));
    end else begin
      $display("timeout: no load result for tag %0d on the cdb", tag);
      error_count++;
    end
  endtask

  task automatic expect_silence(input int cycles, input string what);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (cdb_valid) begin
        $display("unexpected cdb broadcast of tag %0d %s", cdb_tag, what);
        error_count++;
      end
    end
  endtask

  task automatic store_then_load();
    logic [lsu_pkg::data_w-1:0] base;
    logic [lsu_pkg::data_w-1:0] data;
    logic [lsu_pkg::addr_w-1:0] imm;
    base = next_rand(32);
    imm  = lsu_pkg::addr_w'(next_rand(4));
    data = next_rand(32);
    saved_addr = word_addr(base, imm);
    model_mem[saved_addr] = data;
    dispatch_uop(lsu_pkg::op_store, imm, 6'd1, base, 1'b1, '0, data, 1'b1, '0);
    base = next_rand(32); // same word through another base.
    imm  = saved_addr - base[lsu_pkg::addr_w-1:0];
    dispatch_uop(lsu_pkg::op_load, imm, 6'd2, base, 1'b1, '0, '0, 1'b1, '0);
    wait_result(6'd2, model_mem[saved_addr]);
  endtask

  task automatic operand_wakeup();
    logic [lsu_pkg::data_w-1:0] base;
    logic [lsu_pkg::addr_w-1:0] imm;
    base = next_rand(32);
    imm  = saved_addr - base[lsu_pkg::addr_w-1:0];
    dispatch_uop(lsu_pkg::op_load, imm, 6'd10, '0, 1'b0, 6'd40, '0, 1'b1, '0);
    expect_silence(8, "before the base is broadcast");
    ext_strobe(6'd40, base);
    wait_result(6'd10, model_mem[word_addr(base, imm)]);
  endtask

  task automatic load_after_store();
    logic [lsu_pkg::data_w-1:0] base;
    logic [lsu_pkg::data_w-1:0] data;
    logic [lsu_pkg::addr_w-1:0] imm;
    logic [lsu_pkg::addr_w-1:0] addr;
    base = next_rand(32);
    imm  = lsu_pkg::addr_w'(next_rand(4));
    data = next_rand(32);
    addr = word_addr(base, imm);
    dispatch_uop(lsu_pkg::op_store, imm, 6'd12, base, 1'b1, '0, '0, 1'b0, 6'd41);
    base = next_rand(32);
    imm  = addr - base[lsu_pkg::addr_w-1:0];
    dispatch_uop(lsu_pkg::op_load, imm, 6'd13, base, 1'b1, '0, '0, 1'b1, '0);
    expect_silence(6, "while the store data waits");
    ext_strobe(6'd41, data);
    model_mem[addr] = data;
    wait_result(6'd13, model_mem[addr]);
  endtask

  task automatic bus_sharing();
    logic [lsu_pkg::data_w-1:0] base;
    logic [lsu_pkg::addr_w-1:0] imm;
    base = next_rand(32);
    imm  = saved_addr - base[lsu_pkg::addr_w-1:0];
    dispatch_uop(lsu_pkg::op_load, imm, 6'd14, base, 1'b1, '0, '0, 1'b1, '0);
    expect_silence(2, "before the load result"); // result now held in exec.
    ext_strobe(6'd42, next_rand(32));
    wait_result(6'd14, model_mem[saved_addr]);
  endtask

  task automatic full_and_flush();
    for (int i = 0; i < rs_depth; i++) begin
      dispatch_uop(lsu_pkg::op_load, '0, lsu_pkg::tag_w'(20 + i), '0, 1'b0,
                   lsu_pkg::tag_w'(50 + i), '0, 1'b1, '0);
    end
    check_flag(rs_full, 1'b1, "rs_full with every entry waiting");
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    check_flag(rs_full, 1'b0, "rs_full after flush");
    for (int i = 0; i < rs_depth; i++) begin
      ext_strobe(lsu_pkg::tag_w'(50 + i), next_rand(32));
    end
    expect_silence(timeout_cycles, "after flush");
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: fail", name);
    end
  endtask

  initial begin
    int errs;
    rst_n         = 1'b0;
    flush         = 1'b0;
    disp_valid    = 1'b0;
    disp_op       = '0;
    disp_tag      = '0;
    disp_base_val = '0;
    disp_base_tag = '0;
    disp_base_rdy = 1'b0;
    disp_data_val = '0;
    disp_data_tag = '0;
    disp_data_rdy = 1'b0;
    ext_valid     = 1'b0;
    ext_tag       = '0;
    ext_value     = '0;
    saved_addr    = '0;
    lfsr_state    = 32'd87960;
    error_count   = 0;
    pass_count    = 0;
    fail_count    = 0;
    for (int i = 0; i < lsu_pkg::mem_depth; i++) begin
      model_mem[i] = '0; // memory comes out of reset cleared.
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    errs = error_count;
    store_then_load();
    report_test("store_then_load", errs);
    errs = error_count;
    operand_wakeup();
    report_test("operand_wakeup", errs);
    errs = error_count;
    load_after_store();
    report_test("load_after_store", errs);
    errs = error_count;
    bus_sharing();
    report_test("bus_sharing", errs);
    errs = error_count;
    full_and_flush();
    report_test("full_and_flush", errs);
    $display("summary: %0d passing, %0d failing, %0d errors", pass_count, fail_count,
             error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- sources.f
common/lsu_pkg.sv
hdl/lsu_dispatch.sv
lsu_rs/reservation_station_lsu.sv
lsu_rs/lsu_issue_select.sv
hdl/lsu_exec.sv
hdl/cdb_arbiter.sv
hdl/lsu_top.sv
verification/tb_clock.sv
verification/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run the LSU testbench.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module lsu_tb --Mdir obj_dir -o lsu_sim -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
